// ==== design/pio_wmem.sv ====
// Wide memory bank pairing bus dwords into 50-bit entries, app read has RAM priority.
`timescale 1ns/1ps

module pio_wmem import wmem_pkg::*; (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        pio_ce,   // Slow bus clock enable.
	input  logic                        sel,      // Bank selected this cycle.
	input  pio_req_s                    req,      // Registered bus request.
	input  logic                        app_rd,   // Application read strobe.
	input  logic [WMEM_DEPTH_NBITS-1:0] app_addr, // Application entry index.
	output pio_rsp_s                    rsp,      // Bus response.
	output app_rsp_s                    app_rsp   // Application response.
);

	// **********************************************************************
	// Local signals.
	// **********************************************************************
	logic                        wr_lo;       // Low dword write, stage only.
	logic                        wr_hi;       // High dword write, commit.
	logic                        rd_lo;       // Low dword read, fetch entry.
	logic                        rd_hi;       // High dword read, saved bits.
	logic                        rd_go;       // Bus read owns RAM port.
	logic                        rd_go_d1;    // Bus read data at RAM out.
	logic                        rd_save;     // Deferred bus read pending.
	logic                        done;        // Bus access finished.
	logic                        ack_q;
	logic                        app_rd_d1;   // App read owns RAM port.
	logic                        app_rd_d2;   // App data at RAM out.
	logic                        app_ack_q;
	logic [WMEM_DEPTH_NBITS-1:0] app_addr_d1;
	logic [WMEM_DEPTH_NBITS-1:0] ram_raddr;
	logic [WMEM_WIDTH-1:0]       ram_din;
	logic [WMEM_WIDTH-1:0]       ram_dout;
	logic [WMEM_WIDTH-1:0]       app_rdata_q;
	logic [PIO_NBITS-1:0]        stage_lo;    // Staged low dword.
	logic [PIO_NBITS-1:0]        rdata_q;
	logic [WMEM_HI_NBITS-1:0]    hi_saved;    // Upper bits from last low read.

	// **********************************************************************
	// Request decode.
	// **********************************************************************
	assign wr_lo = sel & req.wr & ~req.addr.mem.half;
	assign wr_hi = sel & req.wr & req.addr.mem.half;
	assign rd_lo = sel & req.rd & ~req.addr.mem.half;
	assign rd_hi = sel & req.rd & req.addr.mem.half;

	// New or deferred low read, yields to a pending app read.
	assign rd_go = ~app_rd_d1 & (rd_lo | rd_save);

	assign ram_raddr = app_rd_d1 ? app_addr_d1 : req.addr.mem.entry; // App first.
	assign ram_din   = {req.wdata[WMEM_HI_NBITS-1:0], stage_lo};     // Staged low.

	// **********************************************************************
	// Control state.
	// **********************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_ack_q <= 1'b0;
			rd_save   <= 1'b0;
			rd_go_d1  <= 1'b0;
			done      <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			app_rd_d1 <= app_rd;    // Cycle 1, address registered.
			app_rd_d2 <= app_rd_d1; // Cycle 2, RAM data out.
			app_ack_q <= app_rd_d2; // Cycle 3, output registered.
			rd_go_d1  <= rd_go;
			if (rd_lo & app_rd_d1) begin
				rd_save <= 1'b1; // Port busy, try again next cycle.
			end else if (rd_go) begin
				rd_save <= 1'b0;
			end
			if (wr_lo | wr_hi | rd_hi | rd_go_d1) begin
				done <= 1'b1;
			end else if (pio_ce) begin
				done <= 1'b0; // Consumed by the ack.
			end
			if (pio_ce) begin
				ack_q <= done; // Ack moves on slow clock only.
			end
		end
	end

	// **********************************************************************
	// Data path.
	// **********************************************************************
	always_ff @(posedge clk) begin
		app_addr_d1 <= app_addr;
		app_rdata_q <= ram_dout; // Qualified by app ack.
		if (wr_lo) begin
			stage_lo <= req.wdata;
		end
		if (rd_go_d1) begin
			rdata_q  <= ram_dout[PIO_NBITS-1:0];
			hi_saved <= ram_dout[WMEM_WIDTH-1:PIO_NBITS]; // Kept for high read.
		end else if (rd_hi) begin
			rdata_q <= {{(PIO_NBITS-WMEM_HI_NBITS){1'b0}}, hi_saved};
		end
	end

	assign rsp.ack       = ack_q;
	assign rsp.rdata     = rdata_q;
	assign app_rsp.ack   = app_ack_q;
	assign app_rsp.rdata = app_rdata_q;

	// **********************************************************************
	// Entry storage.
	// **********************************************************************
	ram_1r1w i_ram (
		.clk   (clk),
		.wr    (wr_hi),
		.waddr (req.addr.mem.entry),
		.raddr (ram_raddr),
		.din   (ram_din),
		.dout  (ram_dout)
	);

endmodule

// ==== design/ram_1r1w.sv ====
// Simple dual-port entry RAM with synchronous write and registered read data.
`timescale 1ns/1ps

module ram_1r1w import wmem_pkg::*; (
	input  logic                        clk,
	input  logic                        wr,    // Write enable.
	input  logic [WMEM_DEPTH_NBITS-1:0] waddr, // Write entry.
	input  logic [WMEM_DEPTH_NBITS-1:0] raddr, // Read entry.
	input  logic [WMEM_WIDTH-1:0]       din,   // Write data.
	output logic [WMEM_WIDTH-1:0]       dout   // Read data, one cycle after raddr.
);

	// Storage array, maps to block RAM.
	logic [WMEM_WIDTH-1:0] mem [2**WMEM_DEPTH_NBITS];

	// Write port.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din; // Commit whole entry.
		end
	end

	// Read port, always enabled.
	// Same-address collision returns old data.
	always_ff @(posedge clk) begin
		dout <= mem[raddr]; // Registered output.
	end

endmodule

// ==== design/wmem_array.sv ====
// Wide memory array top with request decoder, four banks and response collector.
`timescale 1ns/1ps

module wmem_array import wmem_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     pio_ce,  // Slow bus clock enable.
	input  pio_req_s pio_req, // Host bus request.
	output pio_rsp_s pio_rsp, // Host bus response.
	input  app_req_s app_req, // Application read request.
	output app_rsp_s app_rsp  // Application read response, 5 cycles later.
);

	// **********************************************************************
	// Internal wiring.
	// **********************************************************************
	logic [WMEM_NBANKS-1:0]      bank_sel;                   // One-hot bus select.
	logic [WMEM_NBANKS-1:0]      app_rd;                     // One-hot app strobe.
	pio_req_s                    bank_req;                   // Shared bus request.
	logic [WMEM_DEPTH_NBITS-1:0] app_addr;                   // Shared app entry.
	pio_rsp_s                    bank_pio_rsp [WMEM_NBANKS];
	app_rsp_s                    bank_app_rsp [WMEM_NBANKS];

	// Decoder, one cycle.
	wmem_req_decode i_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.pio_req  (pio_req),
		.app_req  (app_req),
		.bank_sel (bank_sel),
		.bank_req (bank_req),
		.app_rd   (app_rd),
		.app_addr (app_addr)
	);

	// **********************************************************************
	// Banks, three cycles on the app side.
	// **********************************************************************
	for (genvar g = 0; g < WMEM_NBANKS; g++) begin : g_bank
		pio_wmem i_bank (
			.clk      (clk),
			.arst_n   (arst_n),
			.pio_ce   (pio_ce),
			.sel      (bank_sel[g]),
			.req      (bank_req),
			.app_rd   (app_rd[g]),
			.app_addr (app_addr),
			.rsp      (bank_pio_rsp[g]),
			.app_rsp  (bank_app_rsp[g])
		);
	end

	// Collector, one cycle. App bank is delayed inside.
	wmem_rsp_collect i_collect (
		.clk          (clk),
		.arst_n       (arst_n),
		.bank_sel     (bank_sel),
		.app_bank     (app_req.bank),
		.bank_pio_rsp (bank_pio_rsp),
		.bank_app_rsp (bank_app_rsp),
		.pio_rsp      (pio_rsp),
		.app_rsp      (app_rsp)
	);

endmodule

// ==== design/wmem_pkg.sv ====
// Wide memory package with sizes, bus address views and request/response structs.
package wmem_pkg;

	// **********************************************************************
	// Sizes.
	// **********************************************************************
	localparam int WMEM_WIDTH = 50;                             // Entry width.
	localparam int PIO_NBITS = 32;                              // Bus data width.
	localparam int WMEM_HI_NBITS = WMEM_WIDTH - PIO_NBITS;      // Upper part, 18 bits.
	localparam int WMEM_DEPTH_NBITS = 8;                        // 256 entries per bank.
	localparam int WMEM_NBANKS = 4;                             // Bank count.
	localparam int WMEM_BANK_NBITS = 2;                         // Bank index width.
	localparam int WMEM_OFFS_NBITS = WMEM_DEPTH_NBITS + 3;      // Entry, half, byte.
	localparam int WMEM_BASE_NBITS = PIO_NBITS - WMEM_BANK_NBITS - WMEM_OFFS_NBITS;
	localparam int WMEM_APP_DLY = 4;                            // Bank index pipe depth.

	// Address bits 31:13, window starts at 32'h4000_0000.
	localparam logic [WMEM_BASE_NBITS-1:0] WMEM_BASE = 19'h2_0000;

	// **********************************************************************
	// Bus address, seen by the decoder and by a bank.
	// **********************************************************************
	typedef struct packed {
		logic [WMEM_BASE_NBITS-1:0]  base;     // Window match.
		logic [WMEM_BANK_NBITS-1:0]  bank;     // Bank index.
		logic [WMEM_OFFS_NBITS-1:0]  offs;     // Byte offset in the bank.
	} pio_addr_dec_s;

	typedef struct packed {
		logic [WMEM_BASE_NBITS-1:0]  base;     // Window match.
		logic [WMEM_BANK_NBITS-1:0]  bank;     // Bank index.
		logic [WMEM_DEPTH_NBITS-1:0] entry;    // Entry index, bits 10:3.
		logic                        half;     // 0 low dword, 1 high dword.
		logic [1:0]                  byte_ofs; // Byte in dword, unused.
	} pio_addr_mem_s;

	typedef union packed {
		pio_addr_dec_s dec;                    // Decoder view.
		pio_addr_mem_s mem;                    // Bank view.
	} pio_addr_u;

	// **********************************************************************
	// Requests and responses.
	// **********************************************************************
	typedef struct packed {
		pio_addr_u              addr;          // Byte address.
		logic [PIO_NBITS-1:0]   wdata;         // Write data.
		logic                   rd;            // Read strobe, one cycle.
		logic                   wr;            // Write strobe, one cycle.
	} pio_req_s;

	typedef struct packed {
		logic                   ack;           // Held until next pio_ce.
		logic [PIO_NBITS-1:0]   rdata;         // Valid with ack.
	} pio_rsp_s;

	typedef struct packed {
		logic                        valid;    // Read strobe.
		logic [WMEM_BANK_NBITS-1:0]  bank;     // Bank index.
		logic [WMEM_DEPTH_NBITS-1:0] entry;    // Entry index.
	} app_req_s;

	typedef struct packed {
		logic                   ack;           // Five cycles after valid.
		logic [WMEM_WIDTH-1:0]  rdata;         // Whole entry.
	} app_rsp_s;

endpackage

// ==== design/wmem_req_decode.sv ====
// Request decoder registering bus and application requests and steering them to a bank.
`timescale 1ns/1ps

module wmem_req_decode import wmem_pkg::*; (
	input  logic                        clk,
	input  logic                        arst_n,
	input  pio_req_s                    pio_req,  // Raw bus request.
	input  app_req_s                    app_req,  // Raw application request.
	output logic [WMEM_NBANKS-1:0]      bank_sel, // One-hot bus select.
	output pio_req_s                    bank_req, // Shared registered request.
	output logic [WMEM_NBANKS-1:0]      app_rd,   // One-hot app read strobe.
	output logic [WMEM_DEPTH_NBITS-1:0] app_addr  // Shared app entry index.
);

	logic                   hit;        // Base matches.
	logic                   pio_go;     // Accepted bus request.
	logic [WMEM_NBANKS-1:0] pio_onehot;
	logic [WMEM_NBANKS-1:0] app_onehot;
	pio_addr_u              addr_q;     // Held until next request.
	logic [PIO_NBITS-1:0]   wdata_q;
	logic                   rd_q;
	logic                   wr_q;

	assign hit        = (pio_req.addr.dec.base == WMEM_BASE);
	assign pio_go     = hit & (pio_req.rd | pio_req.wr);
	assign pio_onehot = WMEM_NBANKS'(1) << pio_req.addr.dec.bank;
	assign app_onehot = WMEM_NBANKS'(1) << app_req.bank;

	// Strobes and selects.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank_sel <= '0;
			app_rd   <= '0;
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
		end else begin
			bank_sel <= pio_go ? pio_onehot : '0; // Outside base dropped.
			rd_q     <= hit & pio_req.rd;
			wr_q     <= hit & pio_req.wr;
			app_rd   <= app_req.valid ? app_onehot : '0;
		end
	end

	// Payload, address stays put for a deferred read.
	always_ff @(posedge clk) begin
		if (pio_go) begin
			addr_q  <= pio_req.addr;
			wdata_q <= pio_req.wdata;
		end
		app_addr <= app_req.entry;
	end

	assign bank_req.addr  = addr_q;
	assign bank_req.wdata = wdata_q;
	assign bank_req.rd    = rd_q;
	assign bank_req.wr    = wr_q;

endmodule

// ==== design/wmem_rsp_collect.sv ====
// Response collector merging bank acks and read data into single bus and app responses.
`timescale 1ns/1ps

module wmem_rsp_collect import wmem_pkg::*; (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [WMEM_NBANKS-1:0]     bank_sel,                   // One-hot bus select.
	input  logic [WMEM_BANK_NBITS-1:0] app_bank,                   // Raw app bank index.
	input  pio_rsp_s                   bank_pio_rsp [WMEM_NBANKS],
	input  app_rsp_s                   bank_app_rsp [WMEM_NBANKS],
	output pio_rsp_s                   pio_rsp,
	output app_rsp_s                   app_rsp
);

	logic [WMEM_BANK_NBITS-1:0] sel_idx;                    // Encoded bank_sel.
	logic [WMEM_BANK_NBITS-1:0] pio_bank;                   // Bank of open bus request.
	logic [WMEM_BANK_NBITS-1:0] app_bank_sr [WMEM_APP_DLY]; // In step with banks.
	logic                       pio_ack_or;
	logic                       app_ack_or;
	logic                       pio_ack_q;
	logic                       app_ack_q;
	logic [PIO_NBITS-1:0]       pio_rdata_q;
	logic [WMEM_WIDTH-1:0]      app_rdata_q;

	always_comb begin
		sel_idx    = '0;
		pio_ack_or = 1'b0;
		app_ack_or = 1'b0;
		for (int i = 0; i < WMEM_NBANKS; i++) begin
			if (bank_sel[i]) sel_idx = WMEM_BANK_NBITS'(i);
			pio_ack_or = pio_ack_or | bank_pio_rsp[i].ack;
			app_ack_or = app_ack_or | bank_app_rsp[i].ack;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pio_bank  <= '0;
			pio_ack_q <= 1'b0;
			app_ack_q <= 1'b0;
		end else begin
			if (|bank_sel) pio_bank <= sel_idx; // New bus request.
			pio_ack_q <= pio_ack_or;
			app_ack_q <= app_ack_or;
		end
	end

	always_ff @(posedge clk) begin
		app_bank_sr[0] <= app_bank;
		for (int i = 1; i < WMEM_APP_DLY; i++) app_bank_sr[i] <= app_bank_sr[i-1];
		pio_rdata_q <= bank_pio_rsp[pio_bank].rdata;
		app_rdata_q <= bank_app_rsp[app_bank_sr[WMEM_APP_DLY-1]].rdata;
	end

	assign pio_rsp.ack   = pio_ack_q;
	assign pio_rsp.rdata = pio_rdata_q;
	assign app_rsp.ack   = app_ack_q;
	assign app_rsp.rdata = app_rdata_q;

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset source, 8 ns clock with a 10-cycle reset.
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_NS    = 4;  // Half of the 8 ns period.
	localparam int RST_CYCLES = 10; // Reset length in clock cycles.

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk; // Free running.
	end

	initial begin
		arst_n = 1'b0;                     // Asserted from time zero.
		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;                     // Released on a falling edge.
	end

endmodule

// ==== test/tb_wmem_array.sv ====
// Testbench for the wide memory array with random bus and application traffic against a model.
`timescale 1ns/1ps

module tb_wmem_array import wmem_pkg::*; ();

	localparam int N_WR    = 48;  // Entry pairs written in the first data test.
	localparam int APP_CYC = 64;  // Length of the application burst.
	localparam int BUS_TMO = 64;  // Cycles allowed for each ack edge.
	localparam int BUS_OPS = 4 * N_WR + 48;
	localparam int WDOG_NS = 2 * 8 * (BUS_OPS * (2 * BUS_TMO + 2) + 4 * APP_CYC + 200);

	logic     clk;
	logic     arst_n;
	logic     pio_ce;
	pio_req_s pio_req;
	pio_rsp_s pio_rsp;
	app_req_s app_req;
	app_rsp_s app_rsp;

	// **********************************************************************
	// Reference model and bookkeeping.
	// **********************************************************************
	logic [31:0]           lfsr = 32'hcbbc;
	logic [WMEM_WIDTH-1:0] model_mem [WMEM_NBANKS][2**WMEM_DEPTH_NBITS];
	logic [PIO_NBITS-1:0]  model_stage [WMEM_NBANKS];               // Staged low dwords.
	bit                    written [WMEM_NBANKS * 2**WMEM_DEPTH_NBITS];
	int                    wr_list [$];                             // Keys {bank, entry}.
	int                    due_q [$];                               // Cycle of app ack.
	logic [WMEM_WIDTH-1:0] exp_q [$];                               // Entry due then.
	int                    cyc;
	int                    hot_idx = -1;                            // Collision target.
	bit                    app_stream;
	int                    checks;
	int                    errors;
	int                    test_err;
	int                    tests_ok;
	int                    tests_bad;

	tb_clk_gen i_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	wmem_array i_wmem_array (
		.clk     (clk),
		.arst_n  (arst_n),
		.pio_ce  (pio_ce),
		.pio_req (pio_req),
		.pio_rsp (pio_rsp),
		.app_req (app_req),
		.app_rsp (app_rsp)
	);

	// **********************************************************************
	// Helpers.
	// **********************************************************************
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32, 22, 2, 1.
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] bus_addr(input int key, input logic half);
		return {WMEM_BASE, 2'(key >> 8), 8'(key), half, 2'b00}; // Base, bank, entry.
	endfunction

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic require(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("ERROR at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// One cycle checks the app response and then drives pio_ce and the app request.
	task automatic tick();
		int idx;
		int key;
		@(negedge clk);
		cyc++;
		if (due_q.size() > 0 && due_q[0] == cyc) begin
			compare("app ack", app_rsp.ack, 1'b1);
			compare("app entry", app_rsp.rdata, exp_q[0]);
			void'(due_q.pop_front());
			void'(exp_q.pop_front());
		end else begin
			compare("idle app ack", app_rsp.ack, 1'b0);
		end
		pio_ce        = rand_bits(1);
		app_req.valid = app_stream;
		if (app_stream) begin
			idx = rand_bits(8) % wr_list.size();
			if (hot_idx >= 0 && rand_bits(1)) begin
				idx = hot_idx; // Same entry as the open bus read.
			end
			key           = wr_list[idx];
			app_req.bank  = 2'(key >> 8);
			app_req.entry = 8'(key);
			due_q.push_back(cyc + 5);        // Fixed five-cycle latency.
			exp_q.push_back(model_mem[key >> 8][key & 255]);
		end
	endtask

	task automatic bus_op(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
			input int max_wait, output logic acked, output logic [31:0] rdata);
		int n;
		tick();
		pio_req.addr  = addr;
		pio_req.wdata = wdata;
		pio_req.rd    = ~wr;
		pio_req.wr    = wr;
		tick();
		pio_req.rd = 1'b0; // Strobe lasts one cycle.
		pio_req.wr = 1'b0;
		n = 0;
		while (pio_rsp.ack !== 1'b1 && n < max_wait) begin
			tick();
			n++;
		end
		acked = (pio_rsp.ack === 1'b1);
		rdata = pio_rsp.rdata; // Valid with ack.
		n = 0;
		while (pio_rsp.ack !== 1'b0 && n < max_wait) begin
			tick();
			n++;
		end
		if (acked) begin
			require(pio_rsp.ack === 1'b0, "bus ack did not fall after the access");
		end
	endtask

	task automatic bus_write(input int key, input logic half, input logic [31:0] data);
		logic        acked;
		logic [31:0] rd;
		bus_op(bus_addr(key, half), 1'b1, data, BUS_TMO, acked, rd);
		require(acked, "bus write got no ack");
		if (!half) begin
			model_stage[key >> 8] = data; // Staged only.
		end else begin
			model_mem[key >> 8][key & 255] = {data[WMEM_HI_NBITS-1:0], model_stage[key >> 8]};
		end
	endtask

	task automatic read_check(input int key);
		logic                  acked;
		logic [31:0]           rd;
		logic [WMEM_WIDTH-1:0] exp;
		exp = model_mem[key >> 8][key & 255];
		bus_op(bus_addr(key, 1'b0), 1'b0, '0, BUS_TMO, acked, rd);
		require(acked, "low bus read got no ack");
		compare("low dword", rd, exp[PIO_NBITS-1:0]);
		bus_op(bus_addr(key, 1'b1), 1'b0, '0, BUS_TMO, acked, rd);
		require(acked, "high bus read got no ack");
		compare("high dword", rd, exp[WMEM_WIDTH-1:PIO_NBITS]); // Zero above 18 bits.
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err) begin
			tests_ok++;
			$display("Test %s: passed", name);
		end else begin
			tests_bad++;
			$display("Test %s: failed with %0d errors", name, errors - test_err);
		end
		test_err = errors;
	endtask

	// **********************************************************************
	// Test sequence.
	// **********************************************************************
	initial begin
		int          key;
		logic        acked;
		logic [31:0] rd;
		logic [31:0] addr;
		pio_ce  = 1'b0;
		pio_req = '0;
		app_req = '0;
		@(posedge arst_n);
		repeat (16) begin
			tick();
			compare("bus ack after reset", pio_rsp.ack, 1'b0);
		end
		finish_test("reset state");
		for (int i = 0; i < N_WR; i++) begin
			key = ((i % WMEM_NBANKS) << 8) | rand_bits(8); // Every bank in turn.
			bus_write(key, 1'b0, rand_bits(32));
			bus_write(key, 1'b1, rand_bits(32));
			if (!written[key]) begin
				written[key] = 1'b1;
				wr_list.push_back(key);
			end
		end
		foreach (wr_list[i]) read_check(wr_list[i]);
		finish_test("write then read back");
		for (int i = 0; i < 4; i++) begin
			key = wr_list[rand_bits(8) % wr_list.size()];
			bus_write(key, 1'b0, rand_bits(32)); // Entry must stay as it was.
			read_check(key);
		end
		finish_test("low write stages only");
		app_stream = 1'b1;
		repeat (APP_CYC) tick();
		app_stream = 1'b0;
		repeat (8) tick();
		finish_test("application reads");
		app_stream = 1'b1;
		for (int i = 0; i < 8; i++) begin
			hot_idx = rand_bits(8) % wr_list.size();
			read_check(wr_list[hot_idx]);
		end
		hot_idx    = -1;
		app_stream = 1'b0;
		repeat (8) tick();
		finish_test("bus and application collisions");
		key  = wr_list[rand_bits(8) % wr_list.size()];
		addr = bus_addr(key, 1'b1) ^ {18'(rand_bits(18)), 1'b1, 13'b0}; // Base differs.
		bus_op(addr, 1'b1, rand_bits(32), 40, acked, rd);
		require(!acked, "write outside the window was acknowledged");
		bus_op(addr & ~32'h4, 1'b0, '0, 40, acked, rd);
		require(!acked, "read outside the window was acknowledged");
		read_check(key);
		finish_test("address outside the window");
		$display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
			tests_ok, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog bounded by the worst bus latency of every access.
	initial begin
		#(WDOG_NS);
		$display("Watchdog: the run timed out after %0d ns", WDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== wmem_array.f ====
design/wmem_pkg.sv
design/ram_1r1w.sv
design/pio_wmem.sv
design/wmem_req_decode.sv
design/wmem_rsp_collect.sv
design/wmem_array.sv
test/tb_clk_gen.sv
test/tb_wmem_array.sv
